// ==== Makefile ====
# Verilator build for the console bus testbench

VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = nes_bus_tb
FILELIST  = nes_bus.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== bus/bus_decode.sv ====
////////////////////////////////////////
// Chip selects and slot-qualified strobes from the shared bus,
// plus the sprite DMA trigger and the joypad strobe latch
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bus_decode import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cart_slot,     // PPU write and PRG slot
	input  logic       ppu_read_slot,
	input  addr_t      bus_addr,
	input  logic       bus_rnw,
	input  data_t      bus_dout,
	output logic       ppu_cs,
	output logic       apu_cs,
	output logic       joy1_cs,
	output logic       joy2_cs,
	output logic       ppu_read,
	output logic       ppu_write,
	output logic       apu_read,
	output logic       apu_write,
	output logic       prg_read,
	output logic       prg_write,
	output logic       sprite_trigger,
	output logic       joypad_strobe,
	output logic [1:0] joypad_clock   // Bit 0 first pad, bit 1 second
);

	logic prg_cs;

	assign ppu_cs  = (bus_addr >= PPU_BASE) && (bus_addr < PPU_END);
	assign apu_cs  = (bus_addr >= APU_BASE) && (bus_addr < APU_END); // Joypads included
	assign joy1_cs = (bus_addr == JOY1_ADDR);
	assign joy2_cs = (bus_addr == JOY2_ADDR);
	assign prg_cs  = !ppu_cs && !apu_cs; // Everything else goes to the cart

	// PPU sees one access per CPU cycle
	assign ppu_read  = ppu_cs && bus_rnw && ppu_read_slot;
	assign ppu_write = ppu_cs && !bus_rnw && cart_slot;

	// APU runs off cpu_ce itself
	assign apu_read  = apu_cs && bus_rnw;
	assign apu_write = apu_cs && !bus_rnw;

	assign prg_read  = prg_cs && bus_rnw && cart_slot;
	assign prg_write = prg_cs && !bus_rnw && cart_slot;

	assign sprite_trigger = !bus_rnw && (bus_addr == OAM_DMA_ADDR);

	// One shift clock per joypad read
	assign joypad_clock = {joy2_cs && bus_rnw && ppu_read_slot,
	                       joy1_cs && bus_rnw && ppu_read_slot};

	always_ff @(posedge clk) begin
		if (reset)
			joypad_strobe <= 1'b0;
		else if (joy1_cs && !bus_rnw)
			joypad_strobe <= bus_dout[0]; // Both pads share the strobe
	end

endmodule

`default_nettype wire

// ==== bus/data_bus_mux.sv ====
////////////////////////////////////////
// CPU read-data selection with open-bus hold of the last value
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module data_bus_mux import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       sys_reset,
	input  logic       ppu_cs,
	input  logic       apu_cs,
	input  logic       joy1_cs,
	input  logic       joy2_cs,
	input  logic       mem_allow,   // Cart memory answers this address
	input  logic       mic,         // Famicom microphone bit
	input  addr_t      bus_addr,
	input  data_t      ppu_dout,
	input  data_t      apu_dout,
	input  data_t      mem_din,
	input  logic [3:0] joypad_data, // Pads 1 and 2, then the extra bits
	input  logic [1:0] vaus,        // Paddle bits
	output data_t      data_bus
);

	data_t open_bus; // Last value driven on the bus

	always_ff @(posedge clk) begin
		open_bus <= data_bus;
	end

	always_comb begin
		if (sys_reset) begin
			data_bus = 8'h00;
		end else if (apu_cs) begin
			if (joy1_cs)
				data_bus = {open_bus[7:5], 2'b00, mic, vaus[0], joypad_data[0]};
			else if (joy2_cs)
				data_bus = {open_bus[7:5], joypad_data[3:2], 1'b0, vaus[1], joypad_data[1]};
			else if (bus_addr == APU_STATUS_ADDR)
				data_bus = apu_dout;
			else
				data_bus = open_bus; // Write-only APU registers
		end else if (ppu_cs) begin
			data_bus = ppu_dout;
		end else if (mem_allow) begin
			data_bus = mem_din;
		end else begin
			data_bus = open_bus; // Nothing drives it
		end
	end

endmodule

`default_nettype wire

// ==== common/nes_bus_pkg.sv ====
////////////////////////////////////////
// Shared types, divider counts and bus map for the console bus blocks
// Modules take it with a wildcard import in their header
////////////////////////////////////////
`default_nettype none

package nes_bus_pkg;

	typedef logic [15:0] addr_t; // CPU bus address
	typedef logic [7:0]  data_t; // Data byte

	// Master clock dividers
	localparam logic [3:0] CPU_DIV     = 4'd12; // Master clocks per CPU cycle
	localparam logic [2:0] PPU_DIV     = 3'd4;  // Master clocks per PPU dot
	localparam logic [2:0] PAL_SEQ_LEN = 3'd5;  // CPU cycles per PAL stretch group

	// Register addresses
	localparam addr_t OAM_DMA_ADDR    = 16'h4014; // Write starts sprite DMA
	localparam addr_t OAM_DATA_ADDR   = 16'h2004; // Sprite memory data port
	localparam addr_t JOY1_ADDR       = 16'h4016;
	localparam addr_t JOY2_ADDR       = 16'h4017;
	localparam addr_t APU_STATUS_ADDR = 16'h4015;

	// Device ranges, base inclusive and end exclusive
	localparam addr_t PPU_BASE = 16'h2000;
	localparam addr_t PPU_END  = 16'h4000;
	localparam addr_t APU_BASE = 16'h4000;
	localparam addr_t APU_END  = 16'h4018;

	// Low bit picks PAL timing, Dendy runs on NTSC timing
	typedef enum logic [1:0] {
		sys_ntsc  = 2'd0,
		sys_pal   = 2'd1,
		sys_dendy = 2'd2
	} system_e;

	// Bit 0 set while the CPU is held, bit 1 set while DMA owns the bus
	typedef enum logic [1:0] {
		spr_idle  = 2'b00,
		spr_align = 2'b01,
		spr_run   = 2'b11
	} spr_state_e;

	typedef enum logic {
		dmc_idle    = 1'b0,
		dmc_pending = 1'b1 // Fetch due on the next even cycle
	} dmc_state_e;

endpackage

`default_nettype wire

// ==== dma/dma_controller.sv ====
////////////////////////////////////////
// Sprite page copy and DMC byte fetch; takes the bus from the CPU
// and pauses it, advancing on CPU ticks only
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_controller import nes_bus_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  cpu_ce,
	input  logic  odd_cycle,
	input  logic  sprite_trigger, // Write to OAM_DMA_ADDR seen
	input  logic  dmc_trigger,    // Request from the APU
	input  logic  cpu_rnw,
	input  data_t cpu_dout,       // Source page on trigger
	input  data_t data_bus,
	input  addr_t dmc_addr,
	output addr_t dma_addr,
	output logic  dma_active,     // DMA drives the bus
	output logic  dma_rnw,
	output logic  dmc_ack,
	output logic  pause_cpu,
	output data_t dma_dout
);

	spr_state_e spr_state;
	dmc_state_e dmc_state;
	addr_t      spr_addr;  // Page and low-byte counter
	data_t      last_byte; // Byte fetched on the read half
	logic [8:0] next_low;  // Carry marks the end of the page
	logic       spr_read;

	assign next_low = {1'b0, spr_addr[7:0]} + 9'd1;
	assign spr_read = (spr_state == spr_run) && !odd_cycle && !dmc_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= spr_idle;
			dmc_state <= dmc_idle;
		end else if (cpu_ce) begin
			case (dmc_state)
				dmc_idle:
					if (dmc_trigger && cpu_rnw && !odd_cycle)
						dmc_state <= dmc_pending;
				dmc_pending:
					if (!odd_cycle) // Fetch cycle done
						dmc_state <= dmc_idle;
				default: dmc_state <= dmc_idle;
			endcase

			if (sprite_trigger) begin
				spr_state <= spr_align;
			end else begin
				case (spr_state)
					spr_align:
						if (cpu_rnw && odd_cycle) // Take the bus for the next even cycle
							spr_state <= spr_run;
					spr_run:
						if (odd_cycle && next_low[8])
							spr_state <= spr_idle;
						else if (!odd_cycle && dmc_state == dmc_pending)
							spr_state <= spr_align; // DMC stole the read, waste the odd cycle
					default: spr_state <= spr_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				spr_addr <= {cpu_dout, 8'h00};
			else if (spr_state == spr_run && odd_cycle)
				spr_addr[7:0] <= next_low[7:0]; // Step after each write
			if (spr_read)
				last_byte <= data_bus;
		end
	end

	assign dmc_ack    = (dmc_state == dmc_pending) && !odd_cycle;
	assign dma_active = dmc_ack || (spr_state == spr_run);
	assign dma_rnw    = !odd_cycle; // Reads even, writes odd
	assign dma_dout   = last_byte;
	assign dma_addr   = dmc_ack ? dmc_addr : (!odd_cycle ? spr_addr : OAM_DATA_ADDR);

	// Pending fetch keeps the CPU held even if the request drops
	assign pause_cpu = (spr_state != spr_idle) || dmc_trigger || (dmc_state == dmc_pending);

endmodule

`default_nettype wire

// ==== nes_bus.f ====
common/nes_bus_pkg.sv
verilog/nes_clocks.sv
dma/dma_controller.sv
bus/bus_decode.sv
bus/data_bus_mux.sv
verilog/nes_bus_top.sv
tests/nes_bus_checker.sv
tests/nes_bus_tb.sv

// ==== tests/nes_bus_checker.sv ====
////////////////////////////////////////
// Assertions on DMA ownership and clock-enable pulses,
// bound into the DMA controller by the testbench
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module nes_bus_checker (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic ppu_ce,
	input logic dmc_ack,
	input logic dma_active,
	input logic pause_cpu
);

	logic cycle_odd; // Own even/odd count, even on the first cycle after reset

	always_ff @(posedge clk) begin
		if (reset)
			cycle_odd <= 1'b0;
		else if (cpu_ce)
			cycle_odd <= ~cycle_odd;
	end

	// DMC fetch only ever starts on an even cycle
	ack_even: assert property (@(posedge clk) disable iff (reset)
		$rose(dmc_ack) |-> !cycle_odd)
		else $error("dmc_ack rose on an odd CPU cycle");

	// Bus taken only while the CPU is held, and held a clock before
	active_paused: assert property (@(posedge clk) disable iff (reset)
		dma_active |-> pause_cpu && $past(pause_cpu))
		else $error("dma_active high without pause_cpu");

	cpu_pulse: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |=> !cpu_ce)
		else $error("cpu_ce held for more than one clock");

	ppu_pulse: assert property (@(posedge clk) disable iff (reset)
		ppu_ce |=> !ppu_ce)
		else $error("ppu_ce held for more than one clock");

endmodule

`default_nettype wire

// ==== tests/nes_bus_tb.sv ====
////////////////////////////////////////
// Testbench for the bus top: clock enables, decode table,
// read data model, sprite DMA and DMC fetch
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module nes_bus_tb import nes_bus_pkg::*; ();

	localparam int NUM_ROWS    = 16;
	localparam int TEST_CYCLES = NUM_ROWS + 80 + 20 + 2 * 600; // All phases in CPU cycles
	localparam int TIMEOUT     = 2 * TEST_CYCLES * 16 + 2000;  // 16 clocks worst-case cycle

	typedef struct packed {
		system_e sys;
		addr_t   addr;
		logic    rnw;
		data_t   wdata;
		data_t   dev;   // PPU and APU read data
		logic    mem;   // mem_allow
		int      n_ppu; // Expected PPU strobes
		int      n_prg; // Expected PRG strobes
	} row_t;

	logic clk = 1'b0, reset;
	system_e sys_type;
	addr_t cpu_addr, dmc_addr, bus_addr;
	logic cpu_rnw, dmc_trigger, mem_allow, mic;
	data_t cpu_dout, ppu_dout, apu_dout, mem_din, bus_dout, data_bus;
	logic [3:0] joypad_data;
	logic [1:0] vaus, joypad_clock;
	logic cpu_ce, ppu_ce, cart_ce, odd_cycle, pause_cpu, dmc_ack, bus_rnw;
	logic ppu_read, ppu_write, apu_read, apu_write, prg_read, prg_write, joypad_strobe;

	row_t   table_q[$];
	int     errors = 0;
	int     checks = 0;
	int     clocks = 0;
	integer seed = 91;

	always #5 clk = ~clk;

	nes_bus_top i_dut (.*);

	bind dma_controller nes_bus_checker i_checker (
		.clk(clk), .reset(reset), .cpu_ce(cpu_ce), .ppu_ce(nes_bus_tb.i_dut.ppu_ce),
		.dmc_ack(dmc_ack), .dma_active(dma_active), .pause_cpu(pause_cpu)
	);

	// Hard stop if anything waits forever
	always @(posedge clk) begin
		clocks = clocks + 1;
		if (clocks >= TIMEOUT) begin
			$display("Timeout: no finish after %0d clocks", clocks);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// Returns at the negedge where cpu_ce marks the end of a CPU cycle
	task automatic end_of_cycle();
		do @(negedge clk); while (!cpu_ce);
	endtask

	task automatic count_cycle(output int n_clk, output int n_ppu);
		n_clk = 0;
		n_ppu = 0;
		do begin
			@(negedge clk);
			n_clk++;
			n_ppu += int'(ppu_ce);
		end while (!cpu_ce);
	endtask

	task automatic add_row(input system_e sys, input addr_t addr, input logic rnw,
	                       input data_t wdata, input data_t dev, input logic mem,
	                       input int n_ppu, input int n_prg);
		row_t r;
		r = '{sys, addr, rnw, wdata, dev, mem, n_ppu, n_prg};
		table_q.push_back(r);
	endtask

	// Read data rules, open bus is the last sampled value
	function automatic data_t expect_bus(input addr_t addr, input data_t dev, input logic mem,
	                                     input data_t mdin, input data_t open);
		if (addr == JOY1_ADDR)
			return {open[7:5], 2'b00, mic, vaus[0], joypad_data[0]};
		if (addr == JOY2_ADDR)
			return {open[7:5], joypad_data[3:2], 1'b0, vaus[1], joypad_data[1]};
		if (addr == APU_STATUS_ADDR)
			return dev;
		if (addr >= APU_BASE && addr < APU_END)
			return open;
		if (addr >= PPU_BASE && addr < PPU_END)
			return dev;
		return mem ? mdin : open;
	endfunction

	task automatic ntsc_enables();
		int n_clk, n_ppu;
		logic last_odd;
		repeat (2) end_of_cycle(); // Past sys_reset and the first even cycle
		last_odd = odd_cycle;
		repeat (20) begin
			count_cycle(n_clk, n_ppu);
			check("cpu_ce period", 12, n_clk);
			check("ppu_ce per cycle", 3, n_ppu);
			check("odd_cycle toggle", int'(!last_odd), int'(odd_cycle));
			last_odd = odd_cycle;
		end
	endtask

	task automatic pal_enables();
		int n_clk, sum;
		int dots[12];
		@(posedge clk) sys_type <= sys_pal;
		repeat (2) end_of_cycle();
		for (int i = 0; i < 12; i++)
			count_cycle(n_clk, dots[i]);
		for (int i = 0; i + 5 <= 12; i++) begin
			sum = dots[i] + dots[i+1] + dots[i+2] + dots[i+3] + dots[i+4];
			check("ppu_ce in 5 PAL cycles", 16, sum);
		end
		@(posedge clk) sys_type <= sys_ntsc;
		repeat (2) end_of_cycle(); // Realign allowance
		repeat (4) begin
			count_cycle(n_clk, sum);
			check("cpu_ce period after PAL", 12, n_clk);
		end
	endtask

	task automatic run_table();
		row_t r;
		data_t md, prev_bus;
		logic exp_strobe, in_apu;
		int n_clk, n_cart, n_j1, n_j2;
		int n_ppu_rd, n_ppu_wr, n_prg_rd, n_prg_wr, n_apu_rd, n_apu_wr;
		exp_strobe = 1'b0;
		prev_bus = data_bus;
		foreach (table_q[i]) begin
			r = table_q[i];
			md = data_t'($random(seed));
			@(posedge clk);
			sys_type  <= r.sys;
			cpu_addr  <= r.addr;
			cpu_rnw   <= r.rnw;
			cpu_dout  <= r.wdata;
			ppu_dout  <= r.dev;
			apu_dout  <= r.dev;
			mem_allow <= r.mem;
			mem_din   <= md;
			n_clk = 0;
			n_cart = 0;
			n_ppu_rd = 0;
			n_ppu_wr = 0;
			n_prg_rd = 0;
			n_prg_wr = 0;
			n_apu_rd = 0;
			n_apu_wr = 0;
			n_j1 = 0;
			n_j2 = 0;
			do begin
				@(negedge clk);
				n_clk++;
				n_cart += int'(cart_ce);
				n_ppu_rd += int'(ppu_read);
				n_ppu_wr += int'(ppu_write);
				n_prg_rd += int'(prg_read);
				n_prg_wr += int'(prg_write);
				n_apu_rd += int'(apu_read);
				n_apu_wr += int'(apu_write);
				n_j1 += int'(joypad_clock[0]);
				n_j2 += int'(joypad_clock[1]);
			end while (!cpu_ce);
			if (!r.rnw && r.addr == JOY1_ADDR)
				exp_strobe = r.wdata[0];
			in_apu = (r.addr >= APU_BASE) && (r.addr < APU_END);
			check("cart_ce pulses", 1, n_cart);
			check("ppu_read pulses", r.rnw ? r.n_ppu : 0, n_ppu_rd);
			check("ppu_write pulses", r.rnw ? 0 : r.n_ppu, n_ppu_wr);
			check("prg_read pulses", r.rnw ? r.n_prg : 0, n_prg_rd);
			check("prg_write pulses", r.rnw ? 0 : r.n_prg, n_prg_wr);
			check("apu_read clocks", (in_apu && r.rnw) ? n_clk : 0, n_apu_rd); // Whole cycle
			check("apu_write clocks", (in_apu && !r.rnw) ? n_clk : 0, n_apu_wr);
			check("joypad_clock[0]", int'(r.rnw && r.addr == JOY1_ADDR), n_j1);
			check("joypad_clock[1]", int'(r.rnw && r.addr == JOY2_ADDR), n_j2);
			check("joypad_strobe", int'(exp_strobe), int'(joypad_strobe));
			if (r.rnw)
				check("data_bus", int'(expect_bus(r.addr, r.dev, r.mem, md, prev_bus)),
				      int'(data_bus));
			prev_bus = data_bus;
		end
	endtask

	task automatic dmc_idle_fetch();
		int acks;
		acks = 0;
		@(posedge clk);
		cpu_addr    <= 16'h8000; // CPU sits on a read
		cpu_rnw     <= 1'b1;
		dmc_addr    <= 16'hC123;
		dmc_trigger <= 1'b1;
		mem_allow   <= 1'b1;
		@(negedge clk);
		check("pause_cpu on dmc_trigger", 1, int'(pause_cpu)); // Combinational
		repeat (10) begin
			end_of_cycle();
			if (dmc_ack) begin
				acks++;
				check("dmc bus_addr", int'(dmc_addr), int'(bus_addr));
				check("dmc bus_rnw", 1, int'(bus_rnw));
				@(posedge clk) dmc_trigger <= 1'b0;
			end
		end
		check("dmc_ack pulses", 1, acks);
		check("pause_cpu after fetch", 0, int'(pause_cpu));
	endtask

	// Sprite copy of one page, with an optional DMC request after some pairs
	task automatic sprite_dma(input data_t page, input int dmc_pair);
		int pairs, acks, guard;
		logic have_read, done, raised, drop;
		data_t md, exp_byte;
		pairs = 0;
		acks = 0;
		guard = 0;
		have_read = 1'b0;
		done = 1'b0;
		raised = 1'b0;
		drop = 1'b0;
		exp_byte = 8'h00;
		@(posedge clk);
		cpu_addr  <= OAM_DMA_ADDR;
		cpu_rnw   <= 1'b0;
		cpu_dout  <= page;
		mem_allow <= 1'b1;
		end_of_cycle();
		@(posedge clk);
		cpu_addr <= 16'h8000; // CPU sits on a read
		cpu_rnw  <= 1'b1;
		while (!done && guard < 700) begin
			md = data_t'($random(seed));
			mem_din <= md;
			if (drop) begin
				dmc_trigger <= 1'b0;
				drop = 1'b0;
			end else if (dmc_pair >= 0 && pairs == dmc_pair && !raised) begin
				dmc_trigger <= 1'b1;
				raised = 1'b1;
			end
			end_of_cycle();
			if (!pause_cpu) begin
				done = 1'b1;
				check("pairs when pause_cpu falls", 256, pairs);
				check("last access was a write", 0, int'(have_read));
			end else if (dmc_ack) begin
				acks++;
				drop = 1'b1;
				check("dmc bus_addr", int'(dmc_addr), int'(bus_addr));
				check("dmc bus_rnw", 1, int'(bus_rnw));
			end else if (bus_rnw && bus_addr[15:8] == page) begin
				check("read before write", 0, int'(have_read));
				check("sprite read bus_addr", int'({page, 8'(pairs)}), int'(bus_addr));
				exp_byte = md;
				have_read = 1'b1;
			end else if (!bus_rnw && bus_addr == OAM_DATA_ADDR) begin
				check("write after read", 1, int'(have_read));
				check("OAM write bus_dout", int'(exp_byte), int'(bus_dout));
				have_read = 1'b0;
				pairs++;
			end
			guard++;
			if (!done)
				@(posedge clk);
		end
		if (!done)
			$display("Sprite DMA of page %0h never released the CPU", page);
		check("sprite DMA finished", 1, int'(done));
		check("dmc_ack pulses in copy", (dmc_pair >= 0) ? 1 : 0, acks);
	endtask

	initial begin
		reset       = 1'b1;
		sys_type    = sys_ntsc;
		cpu_addr    = 16'h8000;
		cpu_rnw     = 1'b1;
		cpu_dout    = 8'h00;
		dmc_trigger = 1'b0;
		dmc_addr    = 16'hC000;
		ppu_dout    = 8'h00;
		apu_dout    = 8'h00;
		mem_din     = 8'h00;
		mem_allow   = 1'b0;
		joypad_data = 4'b1010;
		vaus        = 2'b01;
		mic         = 1'b1;

		// sys, addr, rnw, wdata, device data, mem_allow, PPU and PRG strobe counts
		add_row(sys_ntsc,  16'h2002, 1'b1, 8'h00, 8'hA5, 1'b0, 1, 0);
		add_row(sys_ntsc,  16'h2007, 1'b0, 8'h3C, 8'h11, 1'b0, 1, 0);
		add_row(sys_ntsc,  16'h3FFF, 1'b1, 8'h00, 8'h5A, 1'b0, 1, 0);
		add_row(sys_ntsc,  16'h4015, 1'b1, 8'h00, 8'h8F, 1'b0, 0, 0);
		add_row(sys_ntsc,  16'h4000, 1'b1, 8'h00, 8'h22, 1'b1, 0, 0); // Open bus
		add_row(sys_ntsc,  16'h4016, 1'b0, 8'h01, 8'h00, 1'b0, 0, 0);
		add_row(sys_ntsc,  16'h4016, 1'b1, 8'h00, 8'h00, 1'b0, 0, 0);
		add_row(sys_ntsc,  16'h4017, 1'b1, 8'h00, 8'h00, 1'b0, 0, 0);
		add_row(sys_ntsc,  16'h4016, 1'b0, 8'hFE, 8'h00, 1'b0, 0, 0);
		add_row(sys_ntsc,  16'h8000, 1'b1, 8'h00, 8'h00, 1'b1, 0, 1);
		add_row(sys_dendy, 16'hC000, 1'b1, 8'h00, 8'h00, 1'b1, 0, 1);
		add_row(sys_ntsc,  16'h6000, 1'b0, 8'h77, 8'h00, 1'b1, 0, 1);
		add_row(sys_pal,   16'h2005, 1'b0, 8'h40, 8'hC3, 1'b0, 1, 0);
		add_row(sys_ntsc,  16'h0123, 1'b1, 8'h00, 8'h00, 1'b0, 0, 1); // Nothing answers
		add_row(sys_ntsc,  16'h1800, 1'b1, 8'h00, 8'h00, 1'b1, 0, 1);
		add_row(sys_ntsc,  16'h4017, 1'b0, 8'h01, 8'h00, 1'b0, 0, 0);

		repeat (3) @(posedge clk);
		reset <= 1'b0;

		ntsc_enables();
		pal_enables();
		run_table();
		dmc_idle_fetch();
		sprite_dma(8'h03, -1);
		sprite_dma(8'h07, 20);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/nes_bus_top.sv ====
////////////////////////////////////////
// Bus side of the console core; the CPU, PPU, APU and cart attach
// through the ports, and DMA takes the bus while dma_active is high
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module nes_bus_top import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  system_e    sys_type,
	input  addr_t      cpu_addr,
	input  logic       cpu_rnw,
	input  data_t      cpu_dout,
	input  logic       dmc_trigger,
	input  addr_t      dmc_addr,
	input  data_t      ppu_dout,
	input  data_t      apu_dout,
	input  data_t      mem_din,
	input  logic       mem_allow,
	input  logic [3:0] joypad_data,
	input  logic [1:0] vaus,
	input  logic       mic,
	output logic       cpu_ce,
	output logic       ppu_ce,
	output logic       cart_ce,
	output logic       odd_cycle,
	output logic       pause_cpu,
	output logic       dmc_ack,
	output addr_t      bus_addr,
	output data_t      bus_dout,
	output logic       bus_rnw,
	output data_t      data_bus,
	output logic       ppu_read,
	output logic       ppu_write,
	output logic       apu_read,
	output logic       apu_write,
	output logic       prg_read,
	output logic       prg_write,
	output logic       joypad_strobe,
	output logic [1:0] joypad_clock
);

	logic  cart_slot, ppu_read_slot, sys_reset;
	logic  dma_active, dma_rnw, sprite_trigger;
	logic  ppu_cs, apu_cs, joy1_cs, joy2_cs;
	addr_t dma_addr;
	data_t dma_dout;

	// DMA overrides the CPU bus
	assign bus_addr = dma_active ? dma_addr : cpu_addr;
	assign bus_dout = dma_active ? dma_dout : cpu_dout;
	assign bus_rnw  = dma_active ? dma_rnw  : cpu_rnw;

	nes_clocks i_clocks (
		.clk(clk), .reset(reset), .sys_type(sys_type),
		.cpu_ce(cpu_ce), .ppu_ce(ppu_ce), .cart_ce(cart_ce),
		.cart_slot(cart_slot), .ppu_read_slot(ppu_read_slot),
		.odd_cycle(odd_cycle), .sys_reset(sys_reset)
	);

	dma_controller i_dma (
		.clk(clk), .reset(sys_reset), .cpu_ce(cpu_ce), .odd_cycle(odd_cycle),
		.sprite_trigger(sprite_trigger), .dmc_trigger(dmc_trigger),
		.cpu_rnw(cpu_rnw), .cpu_dout(cpu_dout), .data_bus(data_bus),
		.dmc_addr(dmc_addr), .dma_addr(dma_addr), .dma_active(dma_active),
		.dma_rnw(dma_rnw), .dmc_ack(dmc_ack), .pause_cpu(pause_cpu),
		.dma_dout(dma_dout)
	);

	bus_decode i_decode (
		.clk(clk), .reset(sys_reset), .cart_slot(cart_slot),
		.ppu_read_slot(ppu_read_slot), .bus_addr(bus_addr), .bus_rnw(bus_rnw),
		.bus_dout(bus_dout), .ppu_cs(ppu_cs), .apu_cs(apu_cs),
		.joy1_cs(joy1_cs), .joy2_cs(joy2_cs), .ppu_read(ppu_read),
		.ppu_write(ppu_write), .apu_read(apu_read), .apu_write(apu_write),
		.prg_read(prg_read), .prg_write(prg_write),
		.sprite_trigger(sprite_trigger), .joypad_strobe(joypad_strobe),
		.joypad_clock(joypad_clock)
	);

	data_bus_mux i_mux (
		.clk(clk), .sys_reset(sys_reset), .ppu_cs(ppu_cs), .apu_cs(apu_cs),
		.joy1_cs(joy1_cs), .joy2_cs(joy2_cs), .mem_allow(mem_allow), .mic(mic),
		.bus_addr(bus_addr), .ppu_dout(ppu_dout), .apu_dout(apu_dout),
		.mem_din(mem_din), .joypad_data(joypad_data), .vaus(vaus),
		.data_bus(data_bus)
	);

endmodule

`default_nettype wire

// ==== verilog/nes_clocks.sv ====
////////////////////////////////////////
// Master clock division into CPU and PPU enables, phase slots,
// even/odd cycle and the reset hold-off until the first CPU tick
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module nes_clocks import nes_bus_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  system_e sys_type,
	output logic    cpu_ce,
	output logic    ppu_ce,
	output logic    cart_ce,
	output logic    cart_slot,
	output logic    ppu_read_slot,
	output logic    odd_cycle,
	output logic    sys_reset
);

	logic [3:0] div_cpu;       // 1 to CPU_DIV
	logic [2:0] div_ppu;       // 1 to PPU_DIV
	logic [1:0] ppu_tick;      // Dot index inside the current CPU cycle
	logic [2:0] pal_count;     // Position in the PAL stretch group
	system_e    last_sys_type;
	logic       pal;
	logic       stretch;       // Current CPU cycle is one dot longer
	logic [1:0] cart_dot;

	assign pal     = sys_type[0];
	assign stretch = pal && (pal_count == PAL_SEQ_LEN - 3'd1);

	assign cpu_ce = (div_cpu == CPU_DIV);
	assign ppu_ce = (div_ppu == PPU_DIV);

	// First dot after the tick, or second in a stretched cycle
	assign cart_dot      = stretch ? 2'd1 : 2'd0;
	assign cart_slot     = ppu_ce && (ppu_tick == cart_dot);
	assign ppu_read_slot = ppu_ce && (ppu_tick == cart_dot + 2'd1); // One dot later
	assign cart_ce       = cart_slot && !sys_reset; // Mapper held during reset

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu       <= 4'd1;
			div_ppu       <= 3'd1;
			ppu_tick      <= 2'd0;
			pal_count     <= 3'd0;
			last_sys_type <= sys_type;
		end else if (sys_type != last_sys_type) begin
			// Realign everything as if a CPU tick just happened
			div_cpu       <= 4'd1;
			div_ppu       <= 3'd1;
			ppu_tick      <= 2'd0;
			pal_count     <= 3'd0;
			last_sys_type <= sys_type;
		end else begin
			if (!(stretch && ppu_tick == 2'd0)) // Hold CPU count for one dot
				div_cpu <= cpu_ce ? 4'd1 : div_cpu + 4'd1;
			div_ppu <= ppu_ce ? 3'd1 : div_ppu + 3'd1;

			if (cpu_ce)
				ppu_tick <= 2'd0;
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 2'd1;

			if (!pal)
				pal_count <= 3'd0;
			else if (cpu_ce)
				pal_count <= (pal_count == PAL_SEQ_LEN - 3'd1) ? 3'd0 : pal_count + 3'd1;
		end
	end

	// Core reset lasts until a CPU tick, odd_cycle starts even after it
	always_ff @(posedge clk) begin
		if (reset) begin
			sys_reset <= 1'b1;
			odd_cycle <= 1'b0;
		end else if (cpu_ce) begin
			sys_reset <= 1'b0;
			odd_cycle <= sys_reset ? 1'b0 : ~odd_cycle;
		end
	end

endmodule

`default_nettype wire
